// ==== mini16_pkg.sv ====
// mini16 shared definitions
// opcodes, data and register address types, instruction union, decode record
`default_nettype none

package mini16_pkg;

  localparam int width_i = 16;
  localparam int width_d = 16;
  localparam int reg_addr_bits = 5;

  typedef enum logic [4:0]
  {
    op_nop = 5'h00,
    op_st  = 5'h01,
    op_ba  = 5'h04,
    op_bc  = 5'h05,
    op_bl  = 5'h07,
    op_add = 5'h08, // first opcode that writes a register
    op_sub = 5'h09,
    op_and = 5'h0a,
    op_or  = 5'h0b,
    op_xor = 5'h0c,
    op_mv  = 5'h10,
    op_ld  = 5'h17,
    op_sr  = 5'h18,
    op_sl  = 5'h19,
    op_sra = 5'h1a,
    op_cnz = 5'h1c,
    op_cnm = 5'h1d
  } opcode_t;

  typedef logic [reg_addr_bits-1:0] reg_addr_t;
  typedef logic [width_d-1:0] data_t;

  // a field as a source register
  typedef struct packed
  {
    reg_addr_t rd;
    reg_addr_t ra;
    logic      im;
    opcode_t   opcode;
  } inst_reg_t;

  // a field as a signed constant
  typedef struct packed
  {
    reg_addr_t                       rd;
    logic signed [reg_addr_bits-1:0] imm5;
    logic                            im;
    opcode_t                         opcode;
  } inst_imm_t;

  typedef union packed
  {
    inst_reg_t r;
    inst_imm_t i;
  } inst_u;

  // decoded fields, stages 1 to 3
  typedef struct packed
  {
    opcode_t   opcode;
    reg_addr_t rd;
    reg_addr_t ra;
    logic      im;
  } decode_t;

endpackage

`default_nettype wire

// ==== mini16_ifs.sv ====
// stage to stage interfaces of the pipeline
// decode_if (stage 3), operand_if (stage 4), exec_if (stage 5)
`timescale 1ns/1ns
`default_nettype none

interface decode_if;
  mini16_pkg::opcode_t   opcode;
  mini16_pkg::reg_addr_t rd;
  mini16_pkg::reg_addr_t ra; // register address or imm5
  logic                  im;

  modport source (output opcode, rd, ra, im);
  modport sink (input opcode, rd, ra, im);
endinterface

interface operand_if;
  mini16_pkg::opcode_t   opcode;
  mini16_pkg::reg_addr_t rd;
  mini16_pkg::data_t     data_a;
  mini16_pkg::data_t     data_b;

  modport source (output opcode, rd, data_a, data_b);
  modport sink (input opcode, rd, data_a, data_b);
endinterface

interface exec_if;
  mini16_pkg::opcode_t   opcode;
  mini16_pkg::reg_addr_t rd;
  mini16_pkg::data_t     data_a;
  mini16_pkg::data_t     data_b;
  mini16_pkg::data_t     link; // return address, zero extended

  modport source (output opcode, rd, data_a, data_b, link);
  modport sink (input opcode, rd, data_a, data_b, link);
endinterface

`default_nettype wire

// ==== fetch_decode_stage.sv ====
// instruction register, field decode and delay to stage 3
`timescale 1ns/1ns
`default_nettype none

module fetch_decode_stage
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  mini16_pkg::data_t     inst,
  output mini16_pkg::reg_addr_t rd_addr_a,
  output mini16_pkg::reg_addr_t rd_addr_b,
  decode_if.source              dec
);

  mini16_pkg::inst_u   inst_s1; // instruction register
  mini16_pkg::decode_t dec_s1;
  mini16_pkg::decode_t dec_s2;
  mini16_pkg::decode_t dec_s3;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      inst_s1 <= '0; // nop
    end
    else
    begin
      inst_s1 <= mini16_pkg::inst_u'(inst[mini16_pkg::width_i-1:0]);
    end
  end

  always_comb
  begin
    dec_s1.opcode = inst_s1.r.opcode;
    dec_s1.rd     = inst_s1.r.rd;
    dec_s1.im     = inst_s1.r.im;
    dec_s1.ra     = inst_s1.r.ra; // imm5 when im is set, extended in stage 4
  end

  // all-zero record decodes as nop
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      dec_s2 <= '0;
      dec_s3 <= '0;
    end
    else
    begin
      dec_s2 <= dec_s1;
      dec_s3 <= dec_s2;
    end
  end

  // reg file reads combinationally, so the addresses follow the stage 3 record
  assign rd_addr_a = dec_s3.rd;
  assign rd_addr_b = dec_s3.ra;

  assign dec.opcode = dec_s3.opcode;
  assign dec.rd     = dec_s3.rd;
  assign dec.ra     = dec_s3.ra;
  assign dec.im     = dec_s3.im;

endmodule

`default_nettype wire

// ==== operand_stage.sv ====
// operand select (register or sign-extended imm5) and load address register
`timescale 1ns/1ns
`default_nettype none

module operand_stage
#(
  parameter int depth_d = 8
)
(
  input  logic               clk,
  input  logic               rst_n,
  decode_if.sink             dec,
  input  mini16_pkg::data_t  rd_data_a,
  input  mini16_pkg::data_t  rd_data_b,
  output logic [depth_d-1:0] load_addr,
  operand_if.source          opnd
);

  localparam int ext_bits = mini16_pkg::width_d - mini16_pkg::reg_addr_bits;

  mini16_pkg::data_t imm_ext;

  assign imm_ext = {{ext_bits{dec.ra[mini16_pkg::reg_addr_bits-1]}}, dec.ra};

  always_ff @(posedge clk)
  begin
    opnd.rd     <= dec.rd;
    opnd.data_a <= rd_data_a;
    opnd.data_b <= dec.im ? imm_ext : rd_data_b;
    if (!rst_n)
    begin
      opnd.opcode <= mini16_pkg::op_nop;
    end
    else
    begin
      opnd.opcode <= dec.opcode;
    end
  end

  // held until the next ld
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      load_addr <= '0;
    end
    else if (dec.opcode == mini16_pkg::op_ld)
    begin
      load_addr <= rd_data_b[depth_d-1:0]; // address in ra
    end
  end

endmodule

`default_nettype wire

// ==== control_stage.sv ====
// program counter and branch resolution, store port, link address
`timescale 1ns/1ns
`default_nettype none

module control_stage
#(
  parameter int depth_i = 8,
  parameter int depth_d = 8
)
(
  input  logic               clk,
  input  logic               rst_n,
  operand_if.sink            opnd,
  output logic [depth_i-1:0] pc,
  output logic [depth_d-1:0] store_addr,
  output mini16_pkg::data_t  store_data,
  output logic               store_we,
  exec_if.source             ex
);

  logic [depth_i-1:0] pc_inc;
  logic               take_branch;

  assign pc_inc = pc + 1'b1;

  // bc tests data_a, target always in data_b
  assign take_branch = (opnd.opcode == mini16_pkg::op_ba) ||
                       (opnd.opcode == mini16_pkg::op_bl) ||
                       ((opnd.opcode == mini16_pkg::op_bc) && (opnd.data_a != '0));

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      pc <= '0;
    end
    else if (take_branch)
    begin
      pc <= opnd.data_b[depth_i-1:0];
    end
    else
    begin
      pc <= pc_inc;
    end
  end

  // one-cycle strobe per st
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      store_addr <= '0;
      store_data <= '0;
      store_we   <= 1'b0;
    end
    else if (opnd.opcode == mini16_pkg::op_st)
    begin
      store_addr <= opnd.data_a[depth_d-1:0];
      store_data <= opnd.data_b;
      store_we   <= 1'b1;
    end
    else
    begin
      store_addr <= '0;
      store_data <= '0;
      store_we   <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    ex.rd     <= opnd.rd;
    ex.data_a <= opnd.data_a;
    ex.data_b <= opnd.data_b;
    // fetch address + 1, first instruction past the four delay slots
    ex.link   <= mini16_pkg::data_t'(pc_inc);
    if (!rst_n)
    begin
      ex.opcode <= mini16_pkg::op_nop;
    end
    else
    begin
      ex.opcode <= opnd.opcode;
    end
  end

endmodule

`default_nettype wire

// ==== alu_stage.sv ====
// compare flags and one-bit shifts (stage 6), result select and write-back (stage 7)
`timescale 1ns/1ns
`default_nettype none

module alu_stage
(
  input  logic                  clk,
  input  logic                  rst_n,
  exec_if.sink                  ex,
  input  mini16_pkg::data_t     load_data,
  output logic                  wb_we,
  output mini16_pkg::reg_addr_t wb_addr,
  output mini16_pkg::data_t     wb_data
);

  localparam int msb = mini16_pkg::width_d - 1;

  logic                  flag_nz_s6;
  logic                  flag_nm_s6;
  mini16_pkg::data_t     sr_s6;
  mini16_pkg::data_t     sl_s6;
  mini16_pkg::data_t     sra_s6;
  logic                  we_s6;
  mini16_pkg::opcode_t   op_s6;
  mini16_pkg::reg_addr_t rd_s6;
  mini16_pkg::data_t     a_s6;
  mini16_pkg::data_t     b_s6;
  mini16_pkg::data_t     link_s6;

  always_ff @(posedge clk)
  begin
    flag_nz_s6 <= (ex.data_b != '0);
    flag_nm_s6 <= ~ex.data_b[msb]; // sign clear
    sr_s6      <= {1'b0, ex.data_a[msb:1]};
    sl_s6      <= {ex.data_a[msb-1:0], 1'b0};
    sra_s6     <= {ex.data_a[msb], ex.data_a[msb:1]};
    op_s6      <= ex.opcode;
    rd_s6      <= ex.rd;
    a_s6       <= ex.data_a;
    b_s6       <= ex.data_b;
    link_s6    <= ex.link;
  end

  // top two opcode bits non-zero means 08 and up
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      we_s6 <= 1'b0;
    end
    else
    begin
      we_s6 <= (ex.opcode >= mini16_pkg::op_add) || (ex.opcode == mini16_pkg::op_bl);
    end
  end

  always_ff @(posedge clk)
  begin
    case (op_s6)
      mini16_pkg::op_add: wb_data <= a_s6 + b_s6;
      mini16_pkg::op_sub: wb_data <= a_s6 - b_s6;
      mini16_pkg::op_and: wb_data <= a_s6 & b_s6;
      mini16_pkg::op_or:  wb_data <= a_s6 | b_s6;
      mini16_pkg::op_xor: wb_data <= a_s6 ^ b_s6;
      mini16_pkg::op_sr:  wb_data <= sr_s6;
      mini16_pkg::op_sl:  wb_data <= sl_s6;
      mini16_pkg::op_sra: wb_data <= sra_s6;
      mini16_pkg::op_cnz: wb_data <= {mini16_pkg::width_d{flag_nz_s6}};
      mini16_pkg::op_cnm: wb_data <= {mini16_pkg::width_d{flag_nm_s6}};
      mini16_pkg::op_bl:  wb_data <= link_s6;
      mini16_pkg::op_ld:  wb_data <= load_data; // read data of the E+3 address
      default:            wb_data <= b_s6; // mv
    endcase
    wb_addr <= rd_s6;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wb_we <= 1'b0;
    end
    else
    begin
      wb_we <= we_s6;
    end
  end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
// 32 x 16 register file, two combinational reads, one clocked write
`timescale 1ns/1ns
`default_nettype none

module reg_file
(
  input  logic                  clk,
  input  mini16_pkg::reg_addr_t rd_addr_a,
  input  mini16_pkg::reg_addr_t rd_addr_b,
  output mini16_pkg::data_t     rd_data_a,
  output mini16_pkg::data_t     rd_data_b,
  input  logic                  wr_en,
  input  mini16_pkg::reg_addr_t wr_addr,
  input  mini16_pkg::data_t     wr_data
);

  mini16_pkg::data_t regs [2**mini16_pkg::reg_addr_bits];

  // no bypass, a write shows up on the reads after the edge
  assign rd_data_a = regs[rd_addr_a];
  assign rd_data_b = regs[rd_addr_b];

  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      regs[wr_addr] <= wr_data;
    end
  end

endmodule

`default_nettype wire

// ==== mini16_cpu.sv ====
// mini16 core top level
// seven-stage pipeline, instruction and data memory ports
`timescale 1ns/1ns
`default_nettype none

module mini16_cpu
#(
  parameter int depth_i = 8,
  parameter int depth_d = 8
)
(
  input  logic               clk,
  input  logic               rst_n,
  output logic [depth_i-1:0] mem_i_r_addr,
  input  mini16_pkg::data_t  mem_i_r_data,
  output logic [depth_d-1:0] mem_d_r_addr,
  input  mini16_pkg::data_t  mem_d_r_data,
  output logic [depth_d-1:0] mem_d_w_addr,
  output mini16_pkg::data_t  mem_d_w_data,
  output logic               mem_d_we
);

  mini16_pkg::reg_addr_t rd_addr_a;
  mini16_pkg::reg_addr_t rd_addr_b;
  mini16_pkg::data_t     rd_data_a;
  mini16_pkg::data_t     rd_data_b;
  logic                  wb_we;
  mini16_pkg::reg_addr_t wb_addr;
  mini16_pkg::data_t     wb_data;

  decode_if  dec ();
  operand_if opnd ();
  exec_if    ex ();

  fetch_decode_stage u_fetch_decode
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .inst      (mem_i_r_data),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .dec       (dec.source)
  );

  operand_stage #(.depth_d(depth_d)) u_operand
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .dec       (dec.sink),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .load_addr (mem_d_r_addr),
    .opnd      (opnd.source)
  );

  control_stage #(.depth_i(depth_i), .depth_d(depth_d)) u_control
  (
    .clk        (clk),
    .rst_n      (rst_n),
    .opnd       (opnd.sink),
    .pc         (mem_i_r_addr),
    .store_addr (mem_d_w_addr),
    .store_data (mem_d_w_data),
    .store_we   (mem_d_we),
    .ex         (ex.source)
  );

  alu_stage u_alu
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .ex        (ex.sink),
    .load_data (mem_d_r_data),
    .wb_we     (wb_we),
    .wb_addr   (wb_addr),
    .wb_data   (wb_data)
  );

  reg_file u_reg_file
  (
    .clk       (clk),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .wr_en     (wb_we),
    .wr_addr   (wb_addr),
    .wr_data   (wb_data)
  );

endmodule

`default_nettype wire

// ==== tb_mini16.sv ====
// testbench for the mini16 core
// instruction and data memory models, test table, compare tasks, cycle limit
`timescale 1ns/1ns
`default_nettype none

module tb_mini16;

  localparam int depth_i = 8;
  localparam int depth_d = 8;
  localparam int n_rows = 23;
  localparam int cycle_limit = n_rows * 40 + 100;
  localparam int drive_delay = 10;

  localparam logic [depth_i-1:0] branch_pc = 8'd19; // where the op under test sits
  localparam logic [depth_i-1:0] target_pc = 8'hf0; // imm5 of -16, sign extended
  localparam logic [4:0] target_imm = 5'h10;
  localparam logic [depth_d-1:0] store_at = 8'd3; // held in r4
  localparam mini16_pkg::data_t fall_mark = 16'd5;
  localparam mini16_pkg::data_t target_mark = 16'd9;

  typedef struct packed
  {
    mini16_pkg::opcode_t op;
    mini16_pkg::data_t   a;
    mini16_pkg::data_t   b;
    logic                rnd; // replace a and b by random values
    logic                im;
    logic [4:0]          imm;
  } row_t;

  logic                 clk;
  logic                 rst_n;
  logic [depth_i-1:0]   mem_i_r_addr;
  mini16_pkg::data_t    mem_i_r_data;
  logic [depth_d-1:0]   mem_d_r_addr;
  mini16_pkg::data_t    mem_d_r_data;
  logic [depth_d-1:0]   mem_d_w_addr;
  mini16_pkg::data_t    mem_d_w_data;
  logic                 mem_d_we;

  mini16_pkg::data_t    imem [2**depth_i];
  mini16_pkg::data_t    dmem [2**depth_d];
  logic [depth_d-1:0]   store_addr_q [$];
  mini16_pkg::data_t    store_data_q [$];
  logic [depth_i-1:0]   prog_addr;
  integer               seed = 32'h007b6d82;
  int                   cycle_count;

  row_t tests [n_rows] = '{
    '{mini16_pkg::op_add, 16'h0000, 16'h0000, 1'b1, 1'b0, 5'h00},
    '{mini16_pkg::op_sub, 16'h0000, 16'h0000, 1'b1, 1'b0, 5'h00},
    '{mini16_pkg::op_and, 16'h0000, 16'h0000, 1'b1, 1'b0, 5'h00},
    '{mini16_pkg::op_or,  16'h0000, 16'h0000, 1'b1, 1'b0, 5'h00},
    '{mini16_pkg::op_xor, 16'h0000, 16'h0000, 1'b1, 1'b0, 5'h00},
    '{mini16_pkg::op_mv,  16'h0000, 16'h0000, 1'b1, 1'b0, 5'h00},
    '{mini16_pkg::op_mv,  16'h1111, 16'h2222, 1'b0, 1'b1, 5'h1b}, // -5
    '{mini16_pkg::op_mv,  16'h1111, 16'h2222, 1'b0, 1'b1, 5'h10}, // -16
    '{mini16_pkg::op_add, 16'h0000, 16'h0000, 1'b1, 1'b1, 5'h1f},
    '{mini16_pkg::op_sub, 16'h0000, 16'h0000, 1'b1, 1'b1, 5'h07},
    '{mini16_pkg::op_sr,  16'h0000, 16'h0000, 1'b1, 1'b0, 5'h00},
    '{mini16_pkg::op_sl,  16'h0000, 16'h0000, 1'b1, 1'b0, 5'h00},
    '{mini16_pkg::op_sra, 16'h8001, 16'h0000, 1'b0, 1'b0, 5'h00},
    '{mini16_pkg::op_sra, 16'h0000, 16'h0000, 1'b1, 1'b0, 5'h00},
    '{mini16_pkg::op_cnz, 16'h5a5a, 16'h0000, 1'b0, 1'b0, 5'h00},
    '{mini16_pkg::op_cnz, 16'h5a5a, 16'h8000, 1'b0, 1'b0, 5'h00},
    '{mini16_pkg::op_cnm, 16'h5a5a, 16'h0000, 1'b0, 1'b0, 5'h00},
    '{mini16_pkg::op_cnm, 16'h5a5a, 16'hffff, 1'b0, 1'b0, 5'h00},
    '{mini16_pkg::op_cnm, 16'h0000, 16'h0000, 1'b1, 1'b0, 5'h00},
    '{mini16_pkg::op_bc,  16'h0000, 16'h0042, 1'b0, 1'b0, 5'h00}, // not taken
    '{mini16_pkg::op_bc,  16'h1234, 16'h0042, 1'b0, 1'b0, 5'h00}, // taken
    '{mini16_pkg::op_ba,  16'h0000, 16'h0000, 1'b1, 1'b0, 5'h00},
    '{mini16_pkg::op_bl,  16'h0000, 16'h0000, 1'b1, 1'b0, 5'h00}
  };

  mini16_cpu #(.depth_i(depth_i), .depth_d(depth_d)) dut
  (
    .clk          (clk),
    .rst_n        (rst_n),
    .mem_i_r_addr (mem_i_r_addr),
    .mem_i_r_data (mem_i_r_data),
    .mem_d_r_addr (mem_d_r_addr),
    .mem_d_r_data (mem_d_r_data),
    .mem_d_w_addr (mem_d_w_addr),
    .mem_d_w_data (mem_d_w_data),
    .mem_d_we     (mem_d_we)
  );

  assign mem_i_r_data = imem[mem_i_r_addr]; // both memories answer in the cycle
  assign mem_d_r_data = dmem[mem_d_r_addr];

  // strobed writes, every store is logged
  always @(posedge clk)
  begin
    if (mem_d_we)
    begin
      dmem[mem_d_w_addr] <= mem_d_w_data;
      store_addr_q.push_back(mem_d_w_addr);
      store_data_q.push_back(mem_d_w_data);
    end
  end

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial
  begin
    cycle_count = 0;
    while (cycle_count < cycle_limit)
    begin
      @(posedge clk);
      cycle_count = cycle_count + 1;
    end
    $display("timeout: no result after %0d cycles", cycle_limit);
    $display("Test FAILED");
    $fatal(1);
  end

  task automatic next_cycle();
    @(posedge clk);
    #drive_delay;
  endtask

  task automatic check_word(input string name, input mini16_pkg::data_t got,
                            input mini16_pkg::data_t exp);
    if (got !== exp)
    begin
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_addr(input string name, input logic [depth_d-1:0] got,
                            input logic [depth_d-1:0] exp);
    if (got !== exp)
    begin
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_iaddr(input string name, input logic [depth_i-1:0] got,
                             input logic [depth_i-1:0] exp);
    if (got !== exp)
    begin
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("mismatch at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  // rd in 15:11, ra or imm5 in 10:6, im in 5, opcode in 4:0
  function automatic mini16_pkg::data_t encode_inst(input mini16_pkg::opcode_t op,
                                                    input logic [4:0] rd,
                                                    input logic [4:0] field,
                                                    input logic im);
    return {rd, field, im, op};
  endfunction

  task automatic emit(input mini16_pkg::data_t word);
    imem[prog_addr] = word;
    prog_addr = prog_addr + 8'd1;
  endtask

  task automatic emit_nops(input int n);
    repeat (n) emit(encode_inst(mini16_pkg::op_nop, 5'd0, 5'd0, 1'b0));
  endtask

  function automatic logic is_branch(input mini16_pkg::opcode_t op);
    return (op == mini16_pkg::op_ba) || (op == mini16_pkg::op_bc) ||
           (op == mini16_pkg::op_bl);
  endfunction

  // value the final store should carry
  function automatic mini16_pkg::data_t model_result(input mini16_pkg::opcode_t op,
                                                     input mini16_pkg::data_t a,
                                                     input mini16_pkg::data_t b);
    case (op)
      mini16_pkg::op_add: return a + b;
      mini16_pkg::op_sub: return a - b;
      mini16_pkg::op_and: return a & b;
      mini16_pkg::op_or:  return a | b;
      mini16_pkg::op_xor: return a ^ b;
      mini16_pkg::op_mv:  return b;
      mini16_pkg::op_sr:  return a >> 1;
      mini16_pkg::op_sl:  return a << 1;
      mini16_pkg::op_sra: return mini16_pkg::data_t'($signed(a) >>> 1);
      mini16_pkg::op_cnz: return (b != 16'h0000) ? 16'hffff : 16'h0000;
      mini16_pkg::op_cnm: return b[15] ? 16'h0000 : 16'hffff;
      mini16_pkg::op_bc:  return (a != 16'h0000) ? target_mark : fall_mark;
      mini16_pkg::op_ba:  return target_mark;
      mini16_pkg::op_bl:  return {8'h00, branch_pc + 8'd5}; // past the four delay slots
      default:            return 16'h0000;
    endcase
  endfunction

  task automatic build_program(input row_t r);
    for (int k = 0; k < 2**depth_i; k++)
    begin
      imem[k] = '0;
    end
    prog_addr = '0;
    emit(encode_inst(mini16_pkg::op_mv, 5'd5, 5'd1, 1'b1)); // load address of a
    emit(encode_inst(mini16_pkg::op_mv, 5'd6, 5'd2, 1'b1)); // load address of b
    emit(encode_inst(mini16_pkg::op_mv, 5'd4, store_at[4:0], 1'b1));
    emit_nops(5);
    emit(encode_inst(mini16_pkg::op_ld, 5'd3, 5'd5, 1'b0));
    emit_nops(4); // load address must hold until read data is taken
    emit(encode_inst(mini16_pkg::op_ld, 5'd2, 5'd6, 1'b0));
    emit_nops(5);
    if (is_branch(r.op))
    begin
      emit(encode_inst(r.op, (r.op == mini16_pkg::op_bl) ? 5'd8 : 5'd3, target_imm, 1'b1));
      emit_nops(4);
      emit(encode_inst(mini16_pkg::op_mv, 5'd7, fall_mark[4:0], 1'b1));
      emit_nops(5);
      emit(encode_inst(mini16_pkg::op_st, 5'd4, 5'd7, 1'b0));
      prog_addr = target_pc;
      emit(encode_inst(mini16_pkg::op_mv, 5'd7, target_mark[4:0], 1'b1));
      emit_nops(5);
      emit(encode_inst(mini16_pkg::op_st, 5'd4,
                       (r.op == mini16_pkg::op_bl) ? 5'd8 : 5'd7, 1'b0));
    end
    else
    begin
      emit(encode_inst(r.op, 5'd3, r.im ? r.imm : 5'd2, r.im)); // r3 = r3 op b
      emit_nops(5);
      emit(encode_inst(mini16_pkg::op_st, 5'd4, 5'd3, 1'b0));
    end
  endtask

  task automatic run_row(input int idx);
    row_t              r;
    mini16_pkg::data_t a;
    mini16_pkg::data_t b;
    mini16_pkg::data_t b_eff;
    mini16_pkg::data_t expected;
    r = tests[idx];
    a = r.a;
    b = r.b;
    if (r.rnd)
    begin
      a = mini16_pkg::data_t'($random(seed));
      b = mini16_pkg::data_t'($random(seed));
    end
    b_eff = r.im ? {{11{r.imm[4]}}, r.imm} : b;
    expected = model_result(r.op, a, b_eff);
    rst_n = 1'b0;
    build_program(r);
    for (int k = 0; k < 2**depth_d; k++)
    begin
      dmem[k] = mini16_pkg::data_t'(k) ^ 16'hc3a0;
    end
    dmem[1] = a;
    dmem[2] = b;
    repeat (3) next_cycle();
    store_addr_q.delete();
    store_data_q.delete();
    check_iaddr("mem_i_r_addr", mem_i_r_addr, '0);
    check_addr("mem_d_r_addr", mem_d_r_addr, '0);
    check_addr("mem_d_w_addr", mem_d_w_addr, '0);
    check_word("mem_d_w_data", mem_d_w_data, '0);
    check_bit("mem_d_we", mem_d_we, 1'b0);
    rst_n = 1'b1;
    while (store_addr_q.size() == 0)
    begin
      next_cycle();
    end
    check_addr("mem_d_w_addr", store_addr_q[0], store_at);
    check_word("mem_d_w_data", store_data_q[0], expected);
    check_addr("mem_d_r_addr", mem_d_r_addr, 8'd2); // held from the second ld
  endtask

  initial
  begin
    rst_n = 1'b0;
    for (int i = 0; i < n_rows; i++)
    begin
      run_row(i);
    end
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
mini16_pkg.sv
mini16_ifs.sv
fetch_decode_stage.sv
operand_stage.sv
control_stage.sv
alu_stage.sv
reg_file.sv
mini16_cpu.sv
tb_mini16.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the mini16 testbench with Verilator, run it, and scan the log
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f all.f --top-module tb_mini16 -o sim_mini16 &&
{ ./obj_dir/sim_mini16 > sim.log 2>&1 || true; } &&
cat sim.log &&
! grep -q "Test FAILED" sim.log &&
grep -q "Test OK" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
